//--- design/adder_params.svh
// Changing ADDER_WIDTH needs a matching PREFIX_LEVELS and a new split in the top level

`ifndef ADDER_PARAMS_SVH
`define ADDER_PARAMS_SVH

// Operand width in bits
`define ADDER_WIDTH 22

// Knowles tree depth for 22 bits plus carry-in
`define PREFIX_LEVELS 5

// Register stages from operand sample to result
`define ADDER_LATENCY 4

`endif

//--- design/adder_pkg.sv
// Struct widths follow adder_params.svh and the pg words carry one extra bit for the carry-in

`include "adder_params.svh"

package adder_pkg;

	// Operands as presented by the producer
	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] a;
		logic [`ADDER_WIDTH-1:0] b;
		logic                    cin;
	} operand_t;

	// Word passed between pipeline stages
	// Bit 0 holds the carry-in as generate with zero propagate
	typedef struct packed {
		logic                  valid;
		// Per-bit propagate kept for the sum
		logic [`ADDER_WIDTH:0] bit_p;
		// Running group propagate
		logic [`ADDER_WIDTH:0] grp_p;
		// Running group generate
		logic [`ADDER_WIDTH:0] grp_g;
	} pg_word_t;

	// Final sum with carry-out
	typedef struct packed {
		logic                    valid;
		logic [`ADDER_WIDTH-1:0] sum;
		logic                    cout;
	} result_t;

endpackage

//--- design/pg_precompute.sv
// Payload is only loaded on in_valid so data outside a valid strobe is stale

`timescale 1ns/1ps

`include "adder_params.svh"

module pg_precompute (
	input  logic                clk,
	input  logic                arst_n,
	input  adder_pkg::operand_t operands,
	input  logic                in_valid,
	output adder_pkg::pg_word_t pg
);

	logic [`ADDER_WIDTH-1:0] p_bits;
	logic [`ADDER_WIDTH-1:0] g_bits;
	logic [`ADDER_WIDTH:0]   p_word;
	logic [`ADDER_WIDTH:0]   g_word;

	logic                    valid_q;
	logic [`ADDER_WIDTH:0]   p_q;
	logic [`ADDER_WIDTH:0]   g_q;

	// Bitwise propagate and generate
	assign p_bits = operands.a ^ operands.b;
	assign g_bits = operands.a & operands.b;

	// Carry-in takes the place below operand bit 0
	assign p_word = {p_bits, 1'b0};
	assign g_word = {g_bits, operands.cin};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			p_q <= p_word;
			g_q <= g_word;
		end
	end

	// Group values start as the per-bit values
	assign pg.valid = valid_q;
	assign pg.bit_p = p_q;
	assign pg.grp_p = p_q;
	assign pg.grp_g = g_q;

endmodule

//--- design/prefix_levels.sv
// Levels FIRST_LEVEL to LAST_LEVEL must lie in 1 to PREFIX_LEVELS and the top pg bit is never combined

`timescale 1ns/1ps

`include "adder_params.svh"

module prefix_levels #(
	parameter int FIRST_LEVEL = 1,
	parameter int LAST_LEVEL  = `PREFIX_LEVELS
) (
	input  logic                clk,
	input  logic                arst_n,
	input  adder_pkg::pg_word_t pg_in,
	output adder_pkg::pg_word_t pg_out
);

	adder_pkg::pg_word_t   pg_comb;

	logic                  valid_q;
	logic [`ADDER_WIDTH:0] bit_p_q;
	logic [`ADDER_WIDTH:0] grp_p_q;
	logic [`ADDER_WIDTH:0] grp_g_q;

	// Black cell, result packed as {g, p}
	function automatic logic [1:0] black_cell(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo,
		input logic p_lo
	);
		logic g_out;
		logic p_out;
		g_out = g_hi | (p_hi & g_lo);
		p_out = p_hi & p_lo;
		return {g_out, p_out};
	endfunction

	// Grey cell, generate only
	function automatic logic grey_cell(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo
	);
		return g_hi | (p_hi & g_lo);
	endfunction

	// Lateral source for position k
	function automatic int source_of(input int k, input int level);
		int span;
		span = 1 << (level - 1);
		if (level == `PREFIX_LEVELS) begin
			// Knowles pairing where two neighbours share one odd source
			return (k - span) | 1;
		end
		return k - span;
	endfunction

	// One prefix level over the whole word
	function automatic adder_pkg::pg_word_t apply_level(
		input adder_pkg::pg_word_t w,
		input int                  level
	);
		adder_pkg::pg_word_t res;
		int                  span;
		int                  src;
		logic [1:0]          gp;
		res  = w;
		span = 1 << (level - 1);
		// Top position stays as is for the carry-out
		for (int k = 1; k < `ADDER_WIDTH; k++) begin
			if (k >= span) begin
				src = source_of(k, level);
				if (src < span) begin
					// Source group already reaches bit 0
					res.grp_g[k] = grey_cell(w.grp_g[k], w.grp_p[k], w.grp_g[src]);
					res.grp_p[k] = 1'b0;
				end else begin
					gp = black_cell(w.grp_g[k], w.grp_p[k],
						w.grp_g[src], w.grp_p[src]);
					res.grp_g[k] = gp[1];
					res.grp_p[k] = gp[0];
				end
			end
		end
		return res;
	endfunction

	// Each level reads the word left by the one before
	always_comb begin
		pg_comb = pg_in;
		for (int lvl = FIRST_LEVEL; lvl <= LAST_LEVEL; lvl++) begin
			pg_comb = apply_level(pg_comb, lvl);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= pg_comb.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pg_comb.valid) begin
			bit_p_q <= pg_comb.bit_p;
			grp_p_q <= pg_comb.grp_p;
			grp_g_q <= pg_comb.grp_g;
		end
	end

	assign pg_out.valid = valid_q;
	assign pg_out.bit_p = bit_p_q;
	assign pg_out.grp_p = grp_p_q;
	assign pg_out.grp_g = grp_g_q;

endmodule

//--- design/sum_postcompute.sv
// Expects a word with every prefix level applied so grp_g below the top holds the carries

`timescale 1ns/1ps

`include "adder_params.svh"

module sum_postcompute (
	input  logic                clk,
	input  logic                arst_n,
	input  adder_pkg::pg_word_t pg_in,
	output adder_pkg::result_t  result
);

	logic [`ADDER_WIDTH-1:0] carry_in;
	logic [`ADDER_WIDTH-1:0] sum_d;
	logic                    cout_d;

	logic                    valid_q;
	logic [`ADDER_WIDTH-1:0] sum_q;
	logic                    cout_q;

	// Group generate at k is the carry into bit k+1
	assign carry_in = pg_in.grp_g[`ADDER_WIDTH-1:0];

	assign sum_d = pg_in.bit_p[`ADDER_WIDTH:1] ^ carry_in;

	// Top bit was left out of the tree
	assign cout_d = pg_in.grp_g[`ADDER_WIDTH] |
		(pg_in.bit_p[`ADDER_WIDTH] & carry_in[`ADDER_WIDTH-1]);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= pg_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pg_in.valid) begin
			sum_q  <= sum_d;
			cout_q <= cout_d;
		end
	end

	assign result.valid = valid_q;
	assign result.sum   = sum_q;
	assign result.cout  = cout_q;

endmodule

//--- design/knowles_adder_top.sv
// Fixed four-cycle latency with one result per accepted input and no back-pressure

`timescale 1ns/1ps

`include "adder_params.svh"

module knowles_adder_top (
	input  logic                clk,
	input  logic                arst_n,
	input  adder_pkg::operand_t operands,
	input  logic                in_valid,
	output adder_pkg::result_t  result,
	output logic                out_valid
);

	adder_pkg::pg_word_t pre_pg;
	adder_pkg::pg_word_t lo_pg;
	adder_pkg::pg_word_t hi_pg;

	pg_precompute pre_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.operands (operands),
		.in_valid (in_valid),
		.pg       (pre_pg)
	);

	// Spans 1, 2 and 4
	prefix_levels #(
		.FIRST_LEVEL (1),
		.LAST_LEVEL  (3)
	) lo_i (
		.clk    (clk),
		.arst_n (arst_n),
		.pg_in  (pre_pg),
		.pg_out (lo_pg)
	);

	// Span 8 then the Knowles level
	prefix_levels #(
		.FIRST_LEVEL (4),
		.LAST_LEVEL  (`PREFIX_LEVELS)
	) hi_i (
		.clk    (clk),
		.arst_n (arst_n),
		.pg_in  (lo_pg),
		.pg_out (hi_pg)
	);

	sum_postcompute post_i (
		.clk    (clk),
		.arst_n (arst_n),
		.pg_in  (hi_pg),
		.result (result)
	);

	assign out_valid = result.valid;

endmodule

//--- tb/adder_properties.sv
// Bound into knowles_adder_top and assumes in_valid stays low while reset is asserted

`timescale 1ns/1ps

`include "adder_params.svh"

module adder_properties (
	input logic               clk,
	input logic               arst_n,
	input logic               in_valid,
	input logic               out_valid,
	input adder_pkg::result_t result
);

	// Output strobe is the input strobe delayed by the pipeline depth
	latency_matches: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, `ADDER_LATENCY))
		else $error("out_valid does not follow in_valid by the pipeline latency");

	result_known: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !$isunknown(result))
		else $error("result holds unknown bits while out_valid is high");

	// No strobe while held in reset
	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !out_valid)
		else $error("out_valid is high during reset");

endmodule

bind knowles_adder_top adder_properties props_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.result    (result)
);

//--- tb/adder_tb.sv
// Needs tb/adder_golden.txt relative to the run directory, at most 64 vectors of five hex words

`timescale 1ns/1ps

`include "adder_params.svh"

module adder_tb;

	localparam int MAX_VECTORS      = 64;
	localparam int WORDS_PER_VECTOR = 5;
	localparam int MAX_WORDS        = MAX_VECTORS * WORDS_PER_VECTOR;
	localparam int DRIVE_DELAY      = 1;
	localparam int DRAIN_LIMIT      = 50;

	// One result still owed by the DUT
	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] sum;
		logic                    cout;
		logic [31:0]             sample_edge;
	} pending_t;

	logic                clk;
	logic                arst_n;
	logic                in_valid;
	adder_pkg::operand_t operands;
	adder_pkg::result_t  result;
	logic                out_valid;

	logic [31:0] golden_mem [0:MAX_WORDS-1];
	pending_t    expected_q[$];
	logic [31:0] edge_count = 32'd0;
	int          n_vec;

	knowles_adder_top dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.operands  (operands),
		.in_valid  (in_valid),
		.result    (result),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Rising edges seen so far
	always @(posedge clk) begin
		edge_count <= edge_count + 32'd1;
	end

	task automatic end_with_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic check_value(
		input logic [31:0] actual,
		input logic [31:0] expected,
		input string       what
	);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			end_with_failure();
		end
	endtask

	task automatic apply_vector(input int idx);
		int       base;
		pending_t entry;
		base               = idx * WORDS_PER_VECTOR;
		operands.a         = golden_mem[base][`ADDER_WIDTH-1:0];
		operands.b         = golden_mem[base+1][`ADDER_WIDTH-1:0];
		operands.cin       = golden_mem[base+2][0];
		in_valid           = 1'b1;
		entry.sum          = golden_mem[base+3][`ADDER_WIDTH-1:0];
		entry.cout         = golden_mem[base+4][0];
		entry.sample_edge  = edge_count + 32'd1;
		// Golden line must itself be a + b + cin
		check_value(32'({entry.cout, entry.sum}),
			32'(operands.a) + 32'(operands.b) + 32'(operands.cin), "golden entry");
		expected_q.push_back(entry);
	endtask

	task automatic apply_bubble();
		operands = '1;
		in_valid = 1'b0;
	endtask

	always @(negedge clk) begin : check_outputs
		pending_t exp_entry;
		if (!arst_n) begin
			if (out_valid) begin
				$display("out_valid was high while reset was asserted");
				end_with_failure();
			end
		end else if (out_valid) begin
			if (expected_q.size() == 0) begin
				$display("A result appeared with no input pending");
				end_with_failure();
			end else begin
				exp_entry = expected_q.pop_front();
				// Sample edge counts as the first of the latency edges
				check_value(edge_count - exp_entry.sample_edge + 32'd1, 32'(`ADDER_LATENCY),
					"edges from sample to result");
				check_value(32'(result.sum), 32'(exp_entry.sum), "sum");
				check_value(32'(result.cout), 32'(exp_entry.cout), "cout");
			end
		end
	end

	initial begin : run_vectors
		int waited;
		int gap;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		operands = '0;
		for (int i = 0; i < MAX_WORDS; i++) begin
			golden_mem[i] = 32'hFF00_0000 | 32'(i);
		end
		$readmemh("tb/adder_golden.txt", golden_mem);
		n_vec = 0;
		while (n_vec < MAX_VECTORS &&
			golden_mem[n_vec * WORDS_PER_VECTOR][31:24] != 8'hFF) begin
			n_vec++;
		end
		if (n_vec == 0) begin
			$display("The golden file holds no vectors");
			end_with_failure();
		end

		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		// First half back to back, second half with bubbles
		for (int i = 0; i < n_vec; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			apply_vector(i);
			if (i >= n_vec / 2) begin
				gap = (i % 3) + 1;
				for (int g = 0; g < gap; g++) begin
					@(posedge clk);
					#DRIVE_DELAY;
					apply_bubble();
				end
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		apply_bubble();

		waited = 0;
		while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			$display("Timed out waiting for %0d outstanding results", expected_q.size());
			end_with_failure();
		end

		// Idle a little longer to catch a stray result
		repeat (`ADDER_LATENCY + 2) @(posedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

//--- tb/adder_golden.txt
// Columns: a b cin expected_sum expected_cout, all hex
// a and b are 22-bit operands, the sum is 22 bits and cout is one bit
000000 000000 0 000000 0
000000 000000 1 000001 0
3FFFFF 000000 1 000000 1
3FFFFF 000001 0 000000 1
3FFFFF 3FFFFF 0 3FFFFE 1
3FFFFF 3FFFFF 1 3FFFFF 1
2AAAAA 155555 0 3FFFFF 0
2AAAAA 155555 1 000000 1
2AAAAA 2AAAAA 0 155554 1
155555 155555 1 2AAAAB 0
000001 3FFFFF 0 000000 1
200000 200000 0 000000 1
200000 1FFFFF 1 000000 1
1FFFFF 000001 0 200000 0
123456 0ABCDE 0 1CF134 0
3ABCDE 12345F 1 0CF13E 1
0F0F0F 30F0F0 0 3FFFFF 0
0F0F0F 30F0F0 1 000000 1
00FFFF 000001 0 010000 0
3F0000 010000 0 000000 1
000400 000400 1 000801 0
2468AC 13579B 0 37C047 0
3C3C3C 3C3C3C 1 387879 1
1C71C7 238E38 0 3FFFFF 0
1C71C7 238E38 1 000000 1
0000FF 0000FF 0 0001FE 0
155555 2AAAAB 0 000000 1
3FFFFE 000001 1 000000 1
100000 0FFFFF 0 1FFFFF 0
0ACE13 375F2D 1 022D41 1
00000F 3FFFF1 0 000000 1
2B3C4D 000000 0 2B3C4D 0
000000 1E2F30 1 1E2F31 0
3FFFFF 000000 0 3FFFFF 0
11D8A5 2E7A6C 1 005312 1
0753F1 08AC0E 0 0FFFFF 0

//--- list.f
+incdir+design
design/adder_pkg.sv
design/pg_precompute.sv
design/prefix_levels.sv
design/sum_postcompute.sv
design/knowles_adder_top.sv
tb/adder_properties.sv
tb/adder_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module adder_tb -f list.f -o adder_sim

output=$(./obj_dir/adder_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Test OK'; then
	exit 0
fi
exit 1
